/* flist.f */
verilog/icache_geom_pkg.sv
verilog/icache_bus_pkg.sv
verilog/icache_tag_check.sv
verilog/icache_plru.sv
verilog/icache_control.sv
verilog/icache_fetch_stage.sv
verilog/icache_top.sv
verif/tb_clock_gen.sv
verif/tb_icache_checker.sv
verif/tb_icache.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_icache
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

  localparam int wait_limit = 500;

  logic                         clk;
  logic                         reset;
  icache_bus_pkg::fetch_req_t   req = '0;
  logic                         req_valid = 1'b0;
  logic                         req_ready;
  icache_bus_pkg::fetch_rsp_t   rsp;
  logic                         rsp_valid;
  logic                         rsp_ready = 1'b0;
  icache_bus_pkg::mem_req_t     mem_req;
  logic                         mem_req_valid;
  logic                         mem_req_ready = 1'b0;
  icache_geom_pkg::cache_line_t mem_rdata = '0;
  logic                         mem_rdata_valid = 1'b0;
  logic                         burst_active = 1'b0;
  logic                         fill_pending = 1'b0;
  logic [31:0]                  fill_addr = '0;
  int unsigned                  req_wait = 0;
  int unsigned                  fill_wait = 0;
  int                           outstanding;
  int                           value_errors;
  int                           other_errors;

  tb_clock_gen clock_gen (.*);
  icache_top DUT (.*);
  tb_icache_checker check (.*);

  // Word at byte address a holds a's word address XOR C0DE_0000
  function automatic icache_geom_pkg::cache_line_t line_for(input logic [31:0] line_addr);
    icache_geom_pkg::cache_line_t line;
    for (int i = 0; i < icache_geom_pkg::words_per_line; i++) begin
      line[i] = ((line_addr >> 2) + 32'(i)) ^ 32'hC0DE_0000;
    end
    return line;
  endfunction

  function automatic icache_geom_pkg::fetch_addr_t make_addr(input int tag_sel, input int set,
                                                             input int word);
    icache_geom_pkg::fetch_addr_t a;
    a.tag    = 24'h00A000 + 24'(tag_sel);
    a.index  = 3'(set);
    a.offset = {3'(word), 2'b00};
    return a;
  endfunction

  task automatic finish_run(input bit timed_out);
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (timed_out || value_errors != 0 || other_errors != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation passed");
    end
    $finish;
  endtask

  // Leaves req_valid high so the next request can follow at once
  task automatic send(input icache_geom_pkg::fetch_addr_t a);
    int cycles;
    cycles = 0;
    req.addr  <= a;
    req_valid <= 1'b1;
    @(posedge clk);
    while (!req_ready && cycles < wait_limit) begin
      cycles++;
      @(posedge clk);
    end
    if (!req_ready) begin
      $display("Timeout: fetch request not accepted within %0d cycles", wait_limit);
      finish_run(1'b1);
    end
  endtask

  task automatic wait_drain;
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (outstanding != 0 && cycles < wait_limit) begin
      cycles++;
      @(posedge clk);
    end
    if (outstanding != 0) begin
      $display("Timeout: %0d fetches or line fills never completed", outstanding);
      finish_run(1'b1);
    end
  endtask

  always @(posedge clk) begin
    rsp_ready <= burst_active || ($urandom_range(0, 9) < 7);  // 70% ready
  end

  // Backing memory, one line per request after a random delay
  always @(posedge clk) begin
    mem_rdata_valid <= 1'b0;
    if (reset) begin
      mem_req_ready <= 1'b0;
      fill_pending  <= 1'b0;
    end else if (fill_pending) begin
      if (fill_wait == 0) begin
        mem_rdata       <= line_for(fill_addr);
        mem_rdata_valid <= 1'b1;
        fill_pending    <= 1'b0;
      end else begin
        fill_wait <= fill_wait - 1;
      end
    end else if (mem_req_valid && mem_req_ready) begin
      mem_req_ready <= 1'b0;
      fill_addr     <= mem_req.addr;
      fill_pending  <= 1'b1;
      fill_wait     <= $urandom_range(0, 7);  // Line returns 1 to 8 cycles later
    end else if (mem_req_valid) begin
      if (req_wait == 0) mem_req_ready <= 1'b1;
      else req_wait <= req_wait - 1;
    end else begin
      req_wait <= $urandom_range(0, 7);
    end
  end

  initial begin
    int cycles;
    void'($urandom(22));
    cycles = 0;
    @(posedge clk);
    while (reset && cycles < wait_limit) begin
      cycles++;
      @(posedge clk);
    end
    if (reset) begin
      $display("Timeout: reset was never released");
      finish_run(1'b1);
    end
    send(make_addr(0, 2, 0));  // Warm one line, then stream hits from it
    req_valid <= 1'b0;
    wait_drain();
    burst_active <= 1'b1;
    for (int w = 0; w < 8; w++) send(make_addr(0, 2, w));
    req_valid <= 1'b0;
    wait_drain();
    burst_active <= 1'b0;
    // Five tags in set 5 force an eviction, then all five again
    for (int r = 0; r < 2; r++) begin
      for (int t = 0; t < 5; t++) send(make_addr(t, 5, t));
    end
    req_valid <= 1'b0;
    wait_drain();
    for (int n = 0; n < 300; n++) begin
      send(make_addr($urandom_range(0, 5), $urandom_range(0, 7), $urandom_range(0, 7)));
      if ($urandom_range(0, 3) == 0) begin
        req_valid <= 1'b0;
        repeat ($urandom_range(1, 4)) @(posedge clk);
      end
    end
    req_valid <= 1'b0;
    wait_drain();
    finish_run(1'b0);
  end

endmodule

/* verif/tb_icache_checker.sv */
`timescale 1ns/1ps

module tb_icache_checker (
  input  logic                       clk,
  input  logic                       reset,
  input  icache_bus_pkg::fetch_req_t req,
  input  logic                       req_valid,
  input  logic                       req_ready,
  input  icache_bus_pkg::fetch_rsp_t rsp,
  input  logic                       rsp_valid,
  input  logic                       rsp_ready,
  input  icache_bus_pkg::mem_req_t   mem_req,
  input  logic                       mem_req_valid,
  input  logic                       mem_req_ready,
  input  logic                       burst_active,
  output int                         outstanding,
  output int                         value_errors,
  output int                         other_errors
);

  logic [31:0] pending [$];     // Accepted fetches, oldest first
  logic [31:0] mem_expect [$];  // Line fills the model predicts
  icache_geom_pkg::tag_t       model_tag [4][8];
  logic                        model_valid [4][8];
  icache_geom_pkg::plru_bits_t model_plru [8];
  icache_bus_pkg::fetch_rsp_t  last_rsp;
  icache_bus_pkg::mem_req_t    last_mem_req;
  logic                        rsp_held;
  logic                        mem_held;
  logic                        was_reset;
  logic                        burst_seen;
  logic                        hit;
  icache_geom_pkg::way_idx_t   way;
  icache_geom_pkg::set_idx_t   idx;
  logic [31:0]                 oldest;

  task automatic value_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    value_errors++;
    $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic protocol_failure(input string what);
    other_errors++;
    $display("At %0t ns: %s", $time, what);
  endtask

  always @(posedge clk) begin
    if (was_reset) begin  // Idle outputs during and just after reset
      if (rsp_valid !== 1'b0) value_mismatch("rsp_valid", 32'd0, 32'(rsp_valid));
      if (mem_req_valid !== 1'b0) value_mismatch("mem_req_valid", 32'd0, 32'(mem_req_valid));
      if (req_ready !== 1'b1) value_mismatch("req_ready", 32'd1, 32'(req_ready));
    end
    if (reset) begin
      pending.delete();
      mem_expect.delete();
      for (int s = 0; s < 8; s++) begin
        model_plru[s] = '0;
        for (int w = 0; w < 4; w++) model_valid[w][s] = 1'b0;
      end
      rsp_held   = 1'b0;
      mem_held   = 1'b0;
      burst_seen = 1'b0;
    end else begin
      if (rsp_held) begin
        if (!rsp_valid) protocol_failure("rsp_valid dropped while rsp_ready was low");
        if (rsp.addr !== last_rsp.addr) value_mismatch("rsp.addr", last_rsp.addr, rsp.addr);
        if (rsp.data !== last_rsp.data) value_mismatch("rsp.data", last_rsp.data, rsp.data);
      end
      if (mem_held) begin
        if (!mem_req_valid) protocol_failure("mem_req_valid dropped before the transfer");
        if (mem_req.addr !== last_mem_req.addr)
          value_mismatch("mem_req.addr", last_mem_req.addr, mem_req.addr);
      end
      // Hits streamed with rsp_ready high give one response per cycle
      if (!burst_active) burst_seen = 1'b0;
      else if (rsp_valid) burst_seen = 1'b1;
      else if (burst_seen && pending.size() != 0)
        protocol_failure("a cycle without a response inside a run of hits");
      if (rsp_valid && rsp_ready) begin
        if (pending.size() == 0) begin
          protocol_failure("response with no outstanding fetch");
        end else begin
          oldest = pending.pop_front();
          if (rsp.addr !== oldest) value_mismatch("rsp.addr", oldest, rsp.addr);
          if (rsp.data !== ({2'b00, oldest[31:2]} ^ 32'hC0DE_0000))
            value_mismatch("rsp.data", {2'b00, oldest[31:2]} ^ 32'hC0DE_0000, rsp.data);
        end
      end
      if (mem_req_valid && mem_req_ready) begin
        if (mem_expect.size() == 0) begin
          protocol_failure("memory request for a line the model already holds");
        end else begin
          oldest = mem_expect.pop_front();
          if (mem_req.addr !== oldest) value_mismatch("mem_req.addr", oldest, mem_req.addr);
        end
      end
      if (req_valid && req_ready) begin
        pending.push_back(req.addr);
        idx = req.addr.index;
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < 4; w++) begin
          if (model_valid[w][idx] && model_tag[w][idx] == req.addr.tag) begin
            hit = 1'b1;
            way = 2'(w);
          end
        end
        if (!hit) begin
          // Root picks the half, that half's leaf picks the way
          way = model_plru[idx][0] ? {1'b1, model_plru[idx][2]} : {1'b0, model_plru[idx][1]};
          model_valid[way][idx] = 1'b1;
          model_tag[way][idx]   = req.addr.tag;
          mem_expect.push_back({req.addr.tag, idx, 5'b0});
        end
        model_plru[idx][0] = ~way[1];  // Path now points away from this way
        if (way[1]) model_plru[idx][2] = ~way[0];
        else model_plru[idx][1] = ~way[0];
      end
      rsp_held     = rsp_valid && !rsp_ready;
      mem_held     = mem_req_valid && !mem_req_ready;
      last_rsp     = rsp;
      last_mem_req = mem_req;
    end
    was_reset = reset;
    outstanding <= pending.size() + mem_expect.size();
  end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/1ps

module icache_top (
  input  logic                         clk,
  input  logic                         reset,
  input  icache_bus_pkg::fetch_req_t   req,
  input  logic                         req_valid,
  output logic                         req_ready,
  output icache_bus_pkg::fetch_rsp_t   rsp,
  output logic                         rsp_valid,
  input  logic                         rsp_ready,
  output icache_bus_pkg::mem_req_t     mem_req,
  output logic                         mem_req_valid,
  input  logic                         mem_req_ready,
  input  icache_geom_pkg::cache_line_t mem_rdata,
  input  logic                         mem_rdata_valid
);

  icache_bus_pkg::lookup_t   lookup;
  logic                      advance;
  logic                      replay;
  logic                      fill_en;
  icache_geom_pkg::way_idx_t fill_way;
  logic                      touch;
  icache_geom_pkg::way_idx_t touch_way;
  icache_geom_pkg::way_idx_t victim;

  icache_tag_check tag_check (
    .clk,
    .reset,
    .req,
    .advance,
    .replay,
    .fill_en,
    .fill_way,
    .mem_rdata,
    .lookup
  );

  // PLRU follows the set held in stage 1
  icache_plru plru (
    .clk,
    .reset,
    .index     (lookup.addr.index),
    .touch,
    .touch_way,
    .victim
  );

  icache_control control (
    .clk,
    .reset,
    .req_valid,
    .req_ready,
    .lookup,
    .victim,
    .rsp_valid,
    .rsp_ready,
    .advance,
    .replay,
    .fill_en,
    .fill_way,
    .touch,
    .touch_way,
    .mem_req,
    .mem_req_valid,
    .mem_req_ready,
    .mem_rdata_valid
  );

  icache_fetch_stage fetch_stage (
    .clk,
    .reset,
    .lookup,
    .advance,
    .rsp
  );

endmodule

/* verilog/icache_fetch_stage.sv */
`timescale 1ns/1ps

module icache_fetch_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  icache_bus_pkg::lookup_t    lookup,
  input  logic                       advance,
  output icache_bus_pkg::fetch_rsp_t rsp
);

  icache_bus_pkg::lookup_t s2;
  logic [2:0]              word_sel;

  always_ff @(posedge clk) begin
    if (reset) begin
      s2 <= '0;
    end else if (advance) begin
      s2 <= lookup;
    end
  end

  assign word_sel = s2.addr.offset[4:2];  // Word within the line

  assign rsp.addr = s2.addr;
  assign rsp.data = s2.line[word_sel];

endmodule

/* verilog/icache_control.sv */
`timescale 1ns/1ps

module icache_control (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_valid,
  output logic                      req_ready,
  input  icache_bus_pkg::lookup_t   lookup,
  input  icache_geom_pkg::way_idx_t victim,
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  output logic                      advance,
  output logic                      replay,
  output logic                      fill_en,
  output icache_geom_pkg::way_idx_t fill_way,
  output logic                      touch,
  output icache_geom_pkg::way_idx_t touch_way,
  output icache_bus_pkg::mem_req_t  mem_req,
  output logic                      mem_req_valid,
  input  logic                      mem_req_ready,
  input  logic                      mem_rdata_valid
);

  typedef enum logic [1:0] {
    s_run,
    s_request,
    s_wait_fill
  } state_t;

  state_t state;
  logic   s1_valid;
  logic   s2_valid;
  logic   s1_miss;
  icache_geom_pkg::fetch_addr_t line_addr;

  assign s1_miss   = s1_valid && !lookup.hit;
  assign advance   = (state == s_run) && !s1_miss && (!s2_valid || rsp_ready);
  assign req_ready = advance && !replay;  // No new fetch while the refilled line moves on
  assign rsp_valid = s2_valid;

  assign fill_en   = (state == s_wait_fill) && mem_rdata_valid;
  assign touch     = (advance && s1_valid) || fill_en;
  assign touch_way = fill_en ? fill_way : lookup.way;

  always_comb begin
    line_addr        = lookup.addr;
    line_addr.offset = '0;
  end

  assign mem_req.addr  = line_addr;
  assign mem_req_valid = (state == s_request);

  // Victim is fixed when the miss is seen
  always_ff @(posedge clk) begin
    if (state == s_run && s1_miss) begin
      fill_way <= victim;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= s_run;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      replay   <= 1'b0;
    end else begin
      replay <= fill_en;
      if (advance) begin
        s1_valid <= req_valid && req_ready;
        s2_valid <= s1_valid;
      end else if (rsp_ready) begin
        s2_valid <= 1'b0;  // Drain
      end
      case (state)
        s_run:       if (s1_miss) state <= s_request;
        s_request:   if (mem_req_ready) state <= s_wait_fill;
        s_wait_fill: if (mem_rdata_valid) state <= s_run;
        default:     state <= s_run;
      endcase
    end
  end

endmodule

/* verilog/icache_plru.sv */
`timescale 1ns/1ps

module icache_plru (
  input  logic                      clk,
  input  logic                      reset,
  input  icache_geom_pkg::set_idx_t index,
  input  logic                      touch,
  input  icache_geom_pkg::way_idx_t touch_way,
  output icache_geom_pkg::way_idx_t victim
);

  icache_geom_pkg::plru_bits_t [icache_geom_pkg::num_sets-1:0] plru;
  icache_geom_pkg::plru_bits_t cur_bits;
  icache_geom_pkg::plru_bits_t next_bits;

  assign cur_bits = plru[index];

  // Root picks the half, then the leaf of that half picks the way
  assign victim = {cur_bits[0], cur_bits[0] ? cur_bits[2] : cur_bits[1]};

  // Point the path away from the touched way
  always_comb begin
    next_bits    = cur_bits;
    next_bits[0] = ~touch_way[1];
    if (touch_way[1]) begin
      next_bits[2] = ~touch_way[0];
    end else begin
      next_bits[1] = ~touch_way[0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      plru <= '0;
    end else if (touch) begin
      plru[index] <= next_bits;
    end
  end

endmodule

/* verilog/icache_tag_check.sv */
`timescale 1ns/1ps

module icache_tag_check (
  input  logic                         clk,
  input  logic                         reset,
  input  icache_bus_pkg::fetch_req_t   req,
  input  logic                         advance,
  input  logic                         replay,
  input  logic                         fill_en,
  input  icache_geom_pkg::way_idx_t    fill_way,
  input  icache_geom_pkg::cache_line_t mem_rdata,
  output icache_bus_pkg::lookup_t      lookup
);

  localparam int ways = icache_geom_pkg::num_ways;
  localparam int sets = icache_geom_pkg::num_sets;

  icache_geom_pkg::fetch_addr_t s1_addr;
  icache_geom_pkg::fetch_addr_t s1_next;

  logic [ways-1:0][sets-1:0]    valid;
  icache_geom_pkg::tag_t        tags  [ways][sets];
  icache_geom_pkg::cache_line_t lines [ways][sets];

  icache_geom_pkg::way_mask_t   way_mask;

  // Replay keeps the missed address in stage 1
  always_comb begin
    s1_next = s1_addr;
    if (advance && !replay) begin
      s1_next = req.addr;
    end
  end

  always_ff @(posedge clk) begin
    s1_addr <= s1_next;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (fill_en) begin
      valid[fill_way][s1_addr.index] <= 1'b1;
    end
  end

  // Refill always lands at the index held in stage 1
  always_ff @(posedge clk) begin
    if (fill_en) begin
      tags[fill_way][s1_addr.index]  <= s1_addr.tag;
      lines[fill_way][s1_addr.index] <= mem_rdata;
    end
  end

  always_comb begin
    for (int w = 0; w < ways; w++) begin
      way_mask[w] = valid[w][s1_addr.index] && (tags[w][s1_addr.index] == s1_addr.tag);
    end
  end

  // At most one way matches
  always_comb begin
    lookup.addr = s1_addr;
    lookup.hit  = |way_mask;
    lookup.way  = '0;
    lookup.line = lines[0][s1_addr.index];
    for (int w = 0; w < ways; w++) begin
      if (way_mask[w]) begin
        lookup.way  = icache_geom_pkg::way_idx_t'(w);
        lookup.line = lines[w][s1_addr.index];
      end
    end
  end

endmodule

/* verilog/icache_bus_pkg.sv */
package icache_bus_pkg;

  typedef struct packed {
    icache_geom_pkg::fetch_addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic [31:0]           addr;
    icache_geom_pkg::word_t data;
  } fetch_rsp_t;

  // Line-aligned refill address
  typedef struct packed {
    logic [31:0] addr;
  } mem_req_t;

  // Stage 1 result handed to stage 2 and the control block
  typedef struct packed {
    icache_geom_pkg::fetch_addr_t addr;
    logic                         hit;
    icache_geom_pkg::cache_line_t line;
    icache_geom_pkg::way_idx_t    way;
  } lookup_t;

endpackage

/* verilog/icache_geom_pkg.sv */
package icache_geom_pkg;

  // 4 ways x 8 sets x 32-byte lines
  localparam int num_ways       = 4;
  localparam int num_sets       = 8;
  localparam int words_per_line = 8;

  typedef logic [31:0] word_t;
  typedef logic [23:0] tag_t;
  typedef logic [2:0]  set_idx_t;
  typedef logic [4:0]  offset_t;

  // Fetch address split into cache fields
  typedef struct packed {
    tag_t     tag;
    set_idx_t index;
    offset_t  offset;
  } fetch_addr_t;

  typedef word_t [words_per_line-1:0] cache_line_t;  // 256 bits

  typedef logic [1:0] way_idx_t;
  typedef logic [num_ways-1:0] way_mask_t;  // One hit bit per way

  // Bit 0 is the root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
  typedef logic [2:0] plru_bits_t;

endpackage
